// ==== hdl/vlb_params.svh ====
`ifndef VLB_PARAMS_SVH
`define VLB_PARAMS_SVH

//////////////////////////////////////////////////
// fabric shape
//////////////////////////////////////////////////

// switches in the fabric
`define VLB_TOR_NUM 8

// slots in one rotation
`define VLB_SLOT_NUM 2

//////////////////////////////////////////////////
// byte accounting
//////////////////////////////////////////////////

// width of all byte counts
`define VLB_CNT_W 32

// bytes one slot can carry
`define VLB_SLOT_MAX_BYTES 32'h0004_0000

//////////////////////////////////////////////////
// control packet framing
//////////////////////////////////////////////////

// upper 32 bits of every switch mac
`define VLB_MAC_HEAD 32'h8DBC_5C4A

// beats per control packet
`define VLB_PKT_BEATS 9

`endif

// ==== hdl/vlb_sched_pkg.sv ====
`include "vlb_params.svh"

package vlb_sched_pkg;

    // switch and slot indices
    typedef logic [$clog2(`VLB_TOR_NUM)-1:0] tor_id_t;
    typedef logic [$clog2(`VLB_SLOT_NUM)-1:0] slot_id_t;

    typedef logic [`VLB_CNT_W-1:0] byte_cnt_t;

    // one count per destination switch, entry 0 in the low bits
    typedef byte_cnt_t [`VLB_TOR_NUM-1:0] queue_sizes_t;

    // neighbour for this slot and the switch behind it
    typedef struct packed {
        tor_id_t direct;
        tor_id_t two_hop;
    } route_t;

    // split of the slot byte budget
    typedef struct packed {
        byte_cnt_t relay;
        byte_cnt_t direct;
        byte_cnt_t two_hop;
        byte_cnt_t capacity;
    } budget_t;

endpackage

// ==== hdl/vlb_frame_pkg.sv ====
package vlb_frame_pkg;

    import vlb_sched_pkg::*;

    // ethertype field of the control packets
    typedef enum logic [15:0] {
        PKT_CAPACITY = 16'hff00,
        PKT_OFFER    = 16'hff01
    } pkt_type_e;

    // one 64-bit stream beat
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
    } axis_beat_t;

    // fields of a capacity packet from the peer
    typedef struct packed {
        byte_cnt_t capacity;
        byte_cnt_t two_hop;
    } peer_capacity_t;

    // queue snapshot carried by an offer packet
    typedef queue_sizes_t peer_offer_t;

endpackage

// ==== hdl/vlb_route_table.sv ====
`include "vlb_params.svh"

module vlb_route_table
    import vlb_sched_pkg::*;
#(
    parameter int P_MY_TOR_ID = 0,
    parameter int P_MY_OCS_ID = 0
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     i_slot_start,
    input  slot_id_t i_slot_id,
    input  logic     i_slot_done,
    output route_t   o_route,
    output logic     o_route_valid
);

    logic    slot_active;
    logic    start_ok;
    tor_id_t direct_tor;

    // neighbour of switch t in slot s, direction set by the ocs id
    function automatic tor_id_t rot_next(input tor_id_t t, input slot_id_t s);
        int unsigned step;
        step = (2 * int'(s) + 1) % `VLB_TOR_NUM;
        if (P_MY_OCS_ID == 0)
            rot_next = tor_id_t'((int'(t) + step) % `VLB_TOR_NUM);
        else
            rot_next = tor_id_t'((int'(t) + `VLB_TOR_NUM - step) % `VLB_TOR_NUM);
    endfunction

    // starts while a slot runs are dropped
    assign start_ok   = i_slot_start && !slot_active;
    assign direct_tor = rot_next(tor_id_t'(P_MY_TOR_ID), i_slot_id);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            slot_active   <= 1'b0;
            o_route_valid <= 1'b0;
        end else begin
            o_route_valid <= start_ok;
            if (start_ok)
                slot_active <= 1'b1;
            else if (i_slot_done)
                slot_active <= 1'b0;
        end
    end

    // two-hop tor is the neighbour's own entry for the same slot
    always_ff @(posedge i_clk) begin
        if (start_ok) begin
            o_route.direct  <= direct_tor;
            o_route.two_hop <= rot_next(direct_tor, i_slot_id);
        end
    end

endmodule

// ==== hdl/vlb_budget_calc.sv ====
`include "vlb_params.svh"

module vlb_budget_calc
    import vlb_sched_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    input  route_t       i_route,
    input  logic         i_route_valid,
    input  queue_sizes_t i_local_sizes,
    input  queue_sizes_t i_unlocal_sizes,
    output budget_t      o_budget,
    output logic         o_budget_valid
);

    localparam byte_cnt_t SLOT_MAX = `VLB_SLOT_MAX_BYTES;

    logic [1:0]   step;
    logic         budget_valid;
    budget_t      budget_q;
    route_t       route_q;
    queue_sizes_t local_q;
    byte_cnt_t    local_direct;
    byte_cnt_t    local_two_hop;
    byte_cnt_t    rem_after_relay;
    byte_cnt_t    rem_after_direct;
    byte_cnt_t    rem_after_two_hop;

    function automatic byte_cnt_t min_cnt(input byte_cnt_t a, input byte_cnt_t b);
        min_cnt = (a < b) ? a : b;
    endfunction

    assign local_direct  = local_q[route_q.direct];
    assign local_two_hop = local_q[route_q.two_hop];

    // bytes left after each registered term
    // relay above the budget leaves nothing
    assign rem_after_relay   = (budget_q.relay >= SLOT_MAX) ? '0 : SLOT_MAX - budget_q.relay;
    assign rem_after_direct  = rem_after_relay - budget_q.direct;
    assign rem_after_two_hop = rem_after_direct - budget_q.two_hop;

    //////////////////////////////////////////////////
    // step control
    //////////////////////////////////////////////////

    // 0 idle, 1 direct, 2 two-hop, 3 capacity
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            step         <= 2'd0;
            budget_valid <= 1'b0;
        end else begin
            budget_valid <= (step == 2'd3);
            if (i_route_valid)
                step <= 2'd1;
            else if (step != 2'd0)
                step <= step + 2'd1;
        end
    end

    //////////////////////////////////////////////////
    // budget terms
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        // relay comes straight from the sampled unlocal sizes
        if (i_route_valid) begin
            route_q        <= i_route;
            local_q        <= i_local_sizes;
            budget_q.relay <= i_unlocal_sizes[i_route.direct];
        end
        case (step)
            2'd1: budget_q.direct   <= min_cnt(local_direct, rem_after_relay);
            2'd2: budget_q.two_hop  <= min_cnt(local_two_hop, rem_after_direct);
            2'd3: budget_q.capacity <= rem_after_two_hop;
            default: ;
        endcase
    end

    assign o_budget       = budget_q;
    assign o_budget_valid = budget_valid;

endmodule

// ==== hdl/vlb_tx_framer.sv ====
`include "vlb_params.svh"

module vlb_tx_framer
    import vlb_sched_pkg::*;
    import vlb_frame_pkg::*;
#(
    parameter int P_MY_TOR_ID = 0
) (
    input  logic         i_clk,
    input  logic         i_rst,
    input  route_t       i_route,
    input  budget_t      i_budget,
    input  logic         i_budget_valid,
    input  queue_sizes_t i_local_sizes,
    input  logic [63:0]  i_time_stamp,
    output axis_beat_t   o_tx,
    output logic         o_tx_valid,
    input  logic         i_tx_ready,
    output logic         o_slot_done
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_CAPACITY,
        TX_OFFER
    } tx_state_e;

    localparam logic [3:0] LAST_IDX = 4'(`VLB_PKT_BEATS - 1);

    tx_state_e    state;
    logic [3:0]   beat_cnt;
    logic         xfer;
    logic         last_beat;
    budget_t      budget_q;
    queue_sizes_t sizes_q;
    logic [47:0]  dest_mac_q;
    logic [63:0]  ts_q;
    logic [47:0]  own_mac;
    pkt_type_e    pkt_type;
    logic [63:0]  beat_data;

    // prefix, zero byte, then id times 8
    function automatic logic [47:0] mac_of(input tor_id_t t);
        mac_of = {`VLB_MAC_HEAD, 8'h00, 8'(t) << 3};
    endfunction

    assign own_mac   = mac_of(tor_id_t'(P_MY_TOR_ID));
    assign xfer      = o_tx_valid && i_tx_ready;
    assign last_beat = (beat_cnt == LAST_IDX);
    assign pkt_type  = (state == TX_OFFER) ? PKT_OFFER : PKT_CAPACITY;

    //////////////////////////////////////////////////
    // packet sequencing
    //////////////////////////////////////////////////

    // beat index only moves on a transfer
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state    <= TX_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (i_budget_valid) begin
                        state    <= TX_CAPACITY;
                        beat_cnt <= '0;
                    end
                end
                TX_CAPACITY, TX_OFFER: begin
                    if (xfer && last_beat) begin
                        beat_cnt <= '0;
                        state    <= (state == TX_CAPACITY) ? TX_OFFER : TX_IDLE;
                    end else if (xfer) begin
                        beat_cnt <= beat_cnt + 4'd1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // everything both packets carry is frozen for the slot
    always_ff @(posedge i_clk) begin
        if (state == TX_IDLE && i_budget_valid) begin
            budget_q   <= i_budget;
            sizes_q    <= i_local_sizes;
            dest_mac_q <= mac_of(i_route.direct);
            ts_q       <= i_time_stamp;
        end
    end

    //////////////////////////////////////////////////
    // beat contents
    //////////////////////////////////////////////////

    always_comb begin
        beat_data = '0;
        case (beat_cnt)
            4'd0: beat_data = {own_mac, dest_mac_q[47:32]};
            4'd1: beat_data = {dest_mac_q[31:0], pkt_type, 16'h0000};
            4'd2: begin
                if (state == TX_OFFER)
                    beat_data = {budget_q.capacity, 32'h0};
                else
                    beat_data = {budget_q.capacity, budget_q.two_hop};
            end
            4'd3: beat_data = (state == TX_OFFER) ? {sizes_q[7], sizes_q[6]} : ts_q;
            4'd4: beat_data = (state == TX_OFFER) ? {sizes_q[5], sizes_q[4]} : ts_q;
            4'd5: beat_data = (state == TX_OFFER) ? {sizes_q[3], sizes_q[2]} : ts_q;
            4'd6: beat_data = (state == TX_OFFER) ? {sizes_q[1], sizes_q[0]} : ts_q;
            4'd7: beat_data = ts_q;
            default: beat_data = '0;
        endcase
    end

    assign o_tx_valid  = (state != TX_IDLE);
    assign o_tx        = '{data: beat_data, keep: 8'hff, last: last_beat};
    assign o_slot_done = xfer && last_beat && (state == TX_OFFER);

endmodule

// ==== hdl/vlb_rx_parser.sv ====
module vlb_rx_parser
    import vlb_sched_pkg::*;
    import vlb_frame_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_rst,
    input  axis_beat_t     i_rx,
    input  logic           i_rx_valid,
    output peer_capacity_t o_peer_cap,
    output logic           o_peer_cap_valid,
    output queue_sizes_t   o_peer_offer,
    output logic           o_peer_offer_valid
);

    logic [3:0]     beat_cnt;
    logic [15:0]    type_q;
    logic           is_cap;
    logic           is_offer;
    logic           in_sizes;
    logic [2:0]     pair_lo;
    peer_capacity_t cap_q;
    peer_offer_t    offer_q;
    logic           cap_valid;
    logic           offer_valid;

    // type field is only trusted from beat 2 onward
    assign is_cap   = i_rx_valid && (type_q == PKT_CAPACITY);
    assign is_offer = i_rx_valid && (type_q == PKT_OFFER);
    assign in_sizes = (beat_cnt >= 4'd3) && (beat_cnt <= 4'd6);

    // beat 3 holds entries 7/6, beat 6 holds 1/0
    assign pair_lo = 3'((3'd6 - beat_cnt[2:0]) << 1);

    //////////////////////////////////////////////////
    // beat tracking
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            beat_cnt <= '0;
            type_q   <= '0;
        end else if (i_rx_valid) begin
            if (i_rx.last)
                beat_cnt <= '0;
            else
                beat_cnt <= beat_cnt + 4'd1;
            if (beat_cnt == 4'd1)
                type_q <= i_rx.data[31:16];
        end
    end

    //////////////////////////////////////////////////
    // field capture
    //////////////////////////////////////////////////

    // valids land one cycle after the last field beat
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            cap_valid   <= 1'b0;
            offer_valid <= 1'b0;
        end else begin
            cap_valid   <= is_cap && (beat_cnt == 4'd2);
            offer_valid <= is_offer && (beat_cnt == 4'd6);
        end
    end

    always_ff @(posedge i_clk) begin
        if (is_cap && beat_cnt == 4'd2) begin
            cap_q.capacity <= i_rx.data[63:32];
            cap_q.two_hop  <= i_rx.data[31:0];
        end
        if (is_offer && in_sizes) begin
            offer_q[pair_lo + 3'd1] <= i_rx.data[63:32];
            offer_q[pair_lo]        <= i_rx.data[31:0];
        end
    end

    assign o_peer_cap         = cap_q;
    assign o_peer_cap_valid   = cap_valid;
    assign o_peer_offer       = offer_q;
    assign o_peer_offer_valid = offer_valid;

endmodule

// ==== hdl/vlb_port_top.sv ====
module vlb_port_top
    import vlb_sched_pkg::*;
    import vlb_frame_pkg::*;
#(
    parameter int P_MY_TOR_ID = 0,
    parameter int P_MY_OCS_ID = 0
) (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_slot_start,
    input  slot_id_t       i_slot_id,
    input  logic [63:0]    i_time_stamp,
    input  queue_sizes_t   i_local_sizes,
    input  queue_sizes_t   i_unlocal_sizes,
    output axis_beat_t     o_tx,
    output logic           o_tx_valid,
    input  logic           i_tx_ready,
    input  axis_beat_t     i_rx,
    input  logic           i_rx_valid,
    output budget_t        o_budget,
    output logic           o_budget_valid,
    output peer_capacity_t o_peer_cap,
    output logic           o_peer_cap_valid,
    output queue_sizes_t   o_peer_offer,
    output logic           o_peer_offer_valid
);

    route_t  route;
    logic    route_valid;
    budget_t budget;
    logic    budget_valid;
    logic    slot_done;

    //////////////////////////////////////////////////
    // transmit path
    //////////////////////////////////////////////////

    vlb_route_table #(
        .P_MY_TOR_ID (P_MY_TOR_ID),
        .P_MY_OCS_ID (P_MY_OCS_ID)
    ) u_route_table (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_slot_start  (i_slot_start),
        .i_slot_id     (i_slot_id),
        .i_slot_done   (slot_done),
        .o_route       (route),
        .o_route_valid (route_valid)
    );

    vlb_budget_calc u_budget_calc (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_route         (route),
        .i_route_valid   (route_valid),
        .i_local_sizes   (i_local_sizes),
        .i_unlocal_sizes (i_unlocal_sizes),
        .o_budget        (budget),
        .o_budget_valid  (budget_valid)
    );

    // route stays put until the slot ends
    vlb_tx_framer #(
        .P_MY_TOR_ID (P_MY_TOR_ID)
    ) u_tx_framer (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_route        (route),
        .i_budget       (budget),
        .i_budget_valid (budget_valid),
        .i_local_sizes  (i_local_sizes),
        .i_time_stamp   (i_time_stamp),
        .o_tx           (o_tx),
        .o_tx_valid     (o_tx_valid),
        .i_tx_ready     (i_tx_ready),
        .o_slot_done    (slot_done)
    );

    //////////////////////////////////////////////////
    // receive path
    //////////////////////////////////////////////////

    vlb_rx_parser u_rx_parser (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_rx               (i_rx),
        .i_rx_valid         (i_rx_valid),
        .o_peer_cap         (o_peer_cap),
        .o_peer_cap_valid   (o_peer_cap_valid),
        .o_peer_offer       (o_peer_offer),
        .o_peer_offer_valid (o_peer_offer_valid)
    );

    assign o_budget       = budget;
    assign o_budget_valid = budget_valid;

endmodule

// ==== verif/tb_vlb_port.sv ====
`include "vlb_params.svh"

module tb_vlb_port
    import vlb_sched_pkg::*;
    import vlb_frame_pkg::*;
();

    localparam int          MY_TOR      = 2;
    localparam int          MY_OCS      = 1;
    localparam int          CLK_PERIOD  = 40;
    localparam int          RST_CYCLES  = 8;
    localparam int          NUM_SLOTS   = 6;
    localparam int          SLOT_BOUND  = 200;
    localparam int          NUM_RX_PKTS = 3;
    localparam int          RX_BOUND    = 20;
    localparam byte_cnt_t   SLOT_MAX    = `VLB_SLOT_MAX_BYTES;
    localparam logic [63:0] RX_TS       = 64'h0000_00c0_ffee_0042;

    logic           i_clk;
    logic           i_rst;
    logic           i_slot_start;
    slot_id_t       i_slot_id;
    logic [63:0]    i_time_stamp;
    queue_sizes_t   i_local_sizes;
    queue_sizes_t   i_unlocal_sizes;
    axis_beat_t     o_tx;
    logic           o_tx_valid;
    logic           i_tx_ready;
    axis_beat_t     i_rx;
    logic           i_rx_valid;
    budget_t        o_budget;
    logic           o_budget_valid;
    peer_capacity_t o_peer_cap;
    logic           o_peer_cap_valid;
    queue_sizes_t   o_peer_offer;
    logic           o_peer_offer_valid;

    int seed   = 67;
    int errors = 0;
    int checks = 0;

    // stimulus per slot, drawn before the clock runs
    queue_sizes_t slot_local [NUM_SLOTS];
    queue_sizes_t slot_unlocal [NUM_SLOTS];
    logic [63:0]  slot_ts [NUM_SLOTS];
    queue_sizes_t rx_sizes;

    // reference values of the running slot
    queue_sizes_t   exp_local;
    logic [63:0]    exp_ts;
    tor_id_t        exp_direct;
    budget_t        exp_budget;
    peer_capacity_t exp_peer_cap;
    queue_sizes_t   exp_peer_offer;

    int          budget_cnt      = 0;
    int          cap_pkts        = 0;
    int          offer_pkts      = 0;
    int          cap_valid_cnt   = 0;
    int          offer_valid_cnt = 0;
    int          tx_idx          = 0;
    logic        in_offer        = 1'b0;
    logic        stalled         = 1'b0;
    logic [63:0] stall_data;

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // direct neighbour of switch t in slot s
    function automatic tor_id_t neighbour(input int t, input int s);
        int hop;
        hop = 2 * s + 1;
        if (MY_OCS == 0)
            neighbour = tor_id_t'((t + hop) % `VLB_TOR_NUM);
        else
            neighbour = tor_id_t'((t - hop + 4 * `VLB_TOR_NUM) % `VLB_TOR_NUM);
    endfunction

    function automatic logic [47:0] tor_mac(input tor_id_t t);
        tor_mac = {`VLB_MAC_HEAD, 8'h00, 2'b00, t, 3'b000};
    endfunction

    // pair k of an offer, highest entries first
    function automatic logic [63:0] size_pair(input queue_sizes_t q, input int k);
        size_pair = {q[3'(7 - 2 * k)], q[3'(6 - 2 * k)]};
    endfunction

    function automatic budget_t budget_model(input queue_sizes_t loc, input queue_sizes_t unl,
                                             input tor_id_t d, input tor_id_t h);
        budget_t   b;
        byte_cnt_t left;
        b.relay    = unl[d];
        left       = SLOT_MAX - b.relay;
        b.direct   = (loc[d] < left) ? loc[d] : left;
        left       = left - b.direct;
        b.two_hop  = (loc[h] < left) ? loc[h] : left;
        b.capacity = left - b.two_hop;
        budget_model = b;
    endfunction

    task automatic expect_equal(input string name, input logic [255:0] got,
                                input logic [255:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic assert_idle();
        expect_equal("o_budget_valid", 256'(o_budget_valid), 256'(1'b0));
        expect_equal("o_tx_valid", 256'(o_tx_valid), 256'(1'b0));
        expect_equal("o_peer_cap_valid", 256'(o_peer_cap_valid), 256'(1'b0));
        expect_equal("o_peer_offer_valid", 256'(o_peer_offer_valid), 256'(1'b0));
    endtask

    task automatic score_tx_beat();
        logic [47:0] dmac;
        logic [63:0] want;
        dmac = tor_mac(exp_direct);
        case (tx_idx)
            0: want = {tor_mac(tor_id_t'(MY_TOR)), dmac[47:32]};
            1: want = {dmac[31:0], in_offer ? 16'hff01 : 16'hff00, 16'h0000};
            2: want = {exp_budget.capacity, in_offer ? 32'h0 : exp_budget.two_hop};
            3, 4, 5, 6: want = in_offer ? size_pair(exp_local, tx_idx - 3) : exp_ts;
            7: want = exp_ts;
            default: want = '0;
        endcase
        expect_equal($sformatf("o_tx.data beat %0d", tx_idx), 256'(o_tx.data), 256'(want));
        expect_equal("o_tx.keep", 256'(o_tx.keep), 256'(8'hff));
        expect_equal($sformatf("o_tx.last beat %0d", tx_idx), 256'(o_tx.last),
                     256'(tx_idx == 8));
        if (o_tx.last || tx_idx >= 8) begin
            if (in_offer)
                offer_pkts++;
            else
                cap_pkts++;
            in_offer = !in_offer;
            tx_idx   = 0;
        end else begin
            tx_idx++;
        end
    endtask

    // one 9-beat packet from the peer, no gaps
    task automatic send_rx_packet(input logic [15:0] ptype, input logic [63:0] word2,
                                  input queue_sizes_t sizes);
        axis_beat_t  beat;
        logic [47:0] dst_mac;
        int          i;
        dst_mac = tor_mac(tor_id_t'(MY_TOR));
        for (i = 0; i < `VLB_PKT_BEATS; i++) begin
            beat.keep = 8'hff;
            beat.last = (i == `VLB_PKT_BEATS - 1);
            case (i)
                0: beat.data = {tor_mac(3'd6), dst_mac[47:32]};
                1: beat.data = {dst_mac[31:0], ptype, 16'h0000};
                2: beat.data = word2;
                3, 4, 5, 6: beat.data = (ptype == 16'hff00) ? RX_TS : size_pair(sizes, i - 3);
                7: beat.data = RX_TS;
                default: beat.data = '0;
            endcase
            @(posedge i_clk);
            i_rx       <= beat;
            i_rx_valid <= 1'b1;
        end
        @(posedge i_clk);
        i_rx_valid <= 1'b0;
        i_rx       <= '0;
        repeat (3) @(posedge i_clk);
    endtask

    //////////////////////////////////////////////////
    // clock, ready and dut
    //////////////////////////////////////////////////

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ready high about three cycles in four
    always @(posedge i_clk)
        i_tx_ready <= ($random(seed) & 3) != 0;

    vlb_port_top #(
        .P_MY_TOR_ID (MY_TOR),
        .P_MY_OCS_ID (MY_OCS)
    ) uut (
        .i_clk              (i_clk),
        .i_rst              (i_rst),
        .i_slot_start       (i_slot_start),
        .i_slot_id          (i_slot_id),
        .i_time_stamp       (i_time_stamp),
        .i_local_sizes      (i_local_sizes),
        .i_unlocal_sizes    (i_unlocal_sizes),
        .o_tx               (o_tx),
        .o_tx_valid         (o_tx_valid),
        .i_tx_ready         (i_tx_ready),
        .i_rx               (i_rx),
        .i_rx_valid         (i_rx_valid),
        .o_budget           (o_budget),
        .o_budget_valid     (o_budget_valid),
        .o_peer_cap         (o_peer_cap),
        .o_peer_cap_valid   (o_peer_cap_valid),
        .o_peer_offer       (o_peer_offer),
        .o_peer_offer_valid (o_peer_offer_valid)
    );

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////

    always @(posedge i_clk) begin
        if (!i_rst && o_budget_valid) begin
            budget_cnt++;
            expect_equal("o_budget", 256'(o_budget), 256'(exp_budget));
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst) begin
            // a stalled beat has to come back unchanged
            if (stalled) begin
                expect_equal("o_tx_valid", 256'(o_tx_valid), 256'(1'b1));
                expect_equal("o_tx.data", 256'(o_tx.data), 256'(stall_data));
            end
            stalled    = o_tx_valid && !i_tx_ready;
            stall_data = o_tx.data;
            if (o_tx_valid && i_tx_ready)
                score_tx_beat();
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst && o_peer_cap_valid) begin
            cap_valid_cnt++;
            expect_equal("o_peer_cap", 256'(o_peer_cap), 256'(exp_peer_cap));
        end
        if (!i_rst && o_peer_offer_valid) begin
            offer_valid_cnt++;
            expect_equal("o_peer_offer", o_peer_offer, exp_peer_offer);
        end
    end

    initial begin
        #((RST_CYCLES + 1 + NUM_SLOTS * SLOT_BOUND + NUM_RX_PKTS * RX_BOUND) * CLK_PERIOD);
        $display("timeout: the port stopped before all slots and rx packets were done");
        $display("checks run: %0d, errors: %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        int      s;
        int      k;
        int      prev_cap;
        int      prev_offer;
        tor_id_t two_hop;
        i_rst           = 1'b1;
        i_slot_start    = 1'b0;
        i_slot_id       = '0;
        i_time_stamp    = '0;
        i_local_sizes   = '0;
        i_unlocal_sizes = '0;
        i_tx_ready      = 1'b0;
        i_rx            = '0;
        i_rx_valid      = 1'b0;

        // every third slot has local sizes past the budget
        for (s = 0; s < NUM_SLOTS; s++) begin
            for (k = 0; k < `VLB_TOR_NUM; k++) begin
                slot_local[3'(s)][3'(k)] = byte_cnt_t'($random(seed))
                    & ((s % 3 == 0) ? 32'h0007_ffff : 32'h0000_ffff);
                slot_unlocal[3'(s)][3'(k)] = byte_cnt_t'($random(seed)) & 32'h0001_ffff;
            end
            slot_ts[3'(s)] = {32'(s + 1), 32'($random(seed))};
        end
        for (k = 0; k < `VLB_TOR_NUM; k++)
            rx_sizes[3'(k)] = byte_cnt_t'($random(seed));

        repeat (RST_CYCLES) @(posedge i_clk);
        assert_idle();
        i_rst <= 1'b0;
        @(posedge i_clk);
        assert_idle();

        for (s = 0; s < NUM_SLOTS; s++) begin
            exp_local  = slot_local[3'(s)];
            exp_ts     = slot_ts[3'(s)];
            exp_direct = neighbour(MY_TOR, s % 2);
            two_hop    = neighbour(int'(exp_direct), s % 2);
            exp_budget = budget_model(exp_local, slot_unlocal[3'(s)], exp_direct, two_hop);
            @(posedge i_clk);
            i_slot_start    <= 1'b1;
            i_slot_id       <= slot_id_t'(s % 2);
            i_local_sizes   <= exp_local;
            i_unlocal_sizes <= slot_unlocal[3'(s)];
            i_time_stamp    <= exp_ts;
            @(posedge i_clk);
            i_slot_start <= 1'b0;
            // start while the slot runs, must be dropped
            if (s == 2) begin
                repeat (3) @(posedge i_clk);
                i_slot_start <= 1'b1;
                i_slot_id    <= slot_id_t'((s + 1) % 2);
                @(posedge i_clk);
                i_slot_start <= 1'b0;
            end
            while (offer_pkts <= s)
                @(posedge i_clk);
            repeat (2) @(posedge i_clk);
        end

        // peer packets, the last one of an unknown type
        prev_cap              = cap_valid_cnt;
        prev_offer            = offer_valid_cnt;
        exp_peer_cap.capacity = 32'h0001_2345;
        exp_peer_cap.two_hop  = 32'h0000_0abc;
        send_rx_packet(16'hff00, {exp_peer_cap.capacity, exp_peer_cap.two_hop}, '0);
        expect_equal("o_peer_cap_valid pulses", 256'(cap_valid_cnt - prev_cap), 256'(1));
        exp_peer_offer = rx_sizes;
        send_rx_packet(16'hff01, 64'h0000_1000_0000_0000, rx_sizes);
        expect_equal("o_peer_offer_valid pulses", 256'(offer_valid_cnt - prev_offer), 256'(1));
        send_rx_packet(16'hff02, 64'hdead_beef_0000_0001, ~rx_sizes);
        expect_equal("o_peer_cap_valid pulses", 256'(cap_valid_cnt - prev_cap), 256'(1));
        expect_equal("o_peer_offer_valid pulses", 256'(offer_valid_cnt - prev_offer), 256'(1));

        expect_equal("budget valid count", 256'(budget_cnt), 256'(NUM_SLOTS));
        expect_equal("capacity packet count", 256'(cap_pkts), 256'(NUM_SLOTS));
        expect_equal("offer packet count", 256'(offer_pkts), 256'(NUM_SLOTS));

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/vlb_sched_pkg.sv
hdl/vlb_frame_pkg.sv
hdl/vlb_route_table.sv
hdl/vlb_budget_calc.sv
hdl/vlb_tx_framer.sv
hdl/vlb_rx_parser.sv
hdl/vlb_port_top.sv
verif/tb_vlb_port.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the port testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_vlb_port \
    -f flist.f -o tb_vlb_port > build.log 2>&1 \
    && ./obj_dir/tb_vlb_port > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log
